// File: rtl/spart_pkg.sv
////////////////////////////////////////////////////////////
// Shared constants and types for the serial port
// Widths, reset divisor, host register map, status bit
// positions and the engine state encodings
////////////////////////////////////////////////////////////
package spart_pkg;

    // Character and divisor sizes
    localparam int unsigned data_bits      = 8;
    localparam int unsigned div_width      = 16;
    localparam int unsigned oversample     = 16;
    localparam int unsigned tick_cnt_width = $clog2(oversample);
    localparam int unsigned bit_cnt_width  = $clog2(data_bits);

    // 26 at 125 MHz gives 16 x 27 clocks per bit
    localparam logic [div_width-1:0] default_div = div_width'(26);

    // Counter end points
    localparam logic [tick_cnt_width-1:0] last_tick = tick_cnt_width'(oversample - 1);
    localparam logic [tick_cnt_width-1:0] half_tick = tick_cnt_width'(oversample / 2 - 1);
    localparam logic [bit_cnt_width-1:0]  last_bit  = bit_cnt_width'(data_bits - 1);

    // Status byte layout, unused bits read as zero
    localparam int unsigned stat_tx_ready  = 0;
    localparam int unsigned stat_rx_full   = 1;
    localparam int unsigned stat_frame_err = 2;
    localparam int unsigned stat_overrun   = 3;

    typedef enum logic [1:0] {
        reg_data   = 2'd0,
        reg_status = 2'd1,
        reg_div_lo = 2'd2,
        reg_div_hi = 2'd3
    } reg_addr_e;

    typedef enum logic [1:0] {tx_idle, tx_start, tx_data, tx_stop} tx_state_e;
    typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_e;

endpackage

// File: rtl/spart_core_if.sv
////////////////////////////////////////////////////////////
// Link between the host register block and the engines
// Transmit request and ready, plus the received character
// with its strobe and framing flag
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

interface spart_core_if;

    // Transmit side
    logic                             tx_start;
    logic [spart_pkg::data_bits-1:0]  tx_data;
    logic                             tx_ready;

    // Receive side, flag qualified by rx_valid
    logic [spart_pkg::data_bits-1:0]  rx_byte;
    logic                             rx_valid;
    logic                             rx_frame_err;

    modport regs (
        output tx_start, tx_data,
        input  tx_ready, rx_byte, rx_valid, rx_frame_err
    );

    modport tx (
        input  tx_start, tx_data,
        output tx_ready
    );

    modport rx (
        output rx_byte, rx_valid, rx_frame_err
    );

endinterface

// File: rtl/baud_gen.sv
////////////////////////////////////////////////////////////
// Baud rate divider
// Emits a one-clock tick every div+1 clocks, which is the
// 16x oversampling rate shared by both engines
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module baud_gen (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [spart_pkg::div_width-1:0] div,
    output logic                            tick
);

    logic [spart_pkg::div_width-1:0] cnt;

    // Reload on zero, so a new divisor lands at the next wrap
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt  <= spart_pkg::default_div;
            tick <= 1'b0;
        end else if (cnt == '0) begin
            cnt  <= div;
            tick <= 1'b1;
        end else begin
            cnt  <= cnt - 1'b1;
            tick <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    // Back-to-back ticks only happen when the reload value was 0
    a_tick_spacing: assert property (
        @(posedge clk) disable iff (!rst_n)
        (tick && $past(div) != '0) |=> !tick
    );

endmodule

// File: rtl/uart_tx.sv
////////////////////////////////////////////////////////////
// 8N1 transmitter
// Latches a byte on tx_start, then shifts start, eight data
// bits LSB first and stop, sixteen ticks per bit
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module uart_tx (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     tick,
    spart_core_if.tx core,
    output logic     txd
);

    spart_pkg::tx_state_e                   state;
    logic [spart_pkg::data_bits-1:0]        shift_q;
    logic [spart_pkg::tick_cnt_width-1:0]   tick_cnt;
    logic [spart_pkg::bit_cnt_width-1:0]    bit_cnt;
    logic                                   tx_ready_q;
    logic                                   bit_end;

    assign core.tx_ready = tx_ready_q;
    assign bit_end       = tick && (tick_cnt == spart_pkg::last_tick);

    // Character shifter, LSB goes out first
    always_ff @(posedge clk) begin
        if (state == spart_pkg::tx_idle && core.tx_start) begin
            shift_q <= core.tx_data;
        end else if (state != spart_pkg::tx_idle && bit_end) begin
            shift_q <= {1'b1, shift_q[spart_pkg::data_bits-1:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= spart_pkg::tx_idle;
            tick_cnt   <= '0;
            bit_cnt    <= '0;
            tx_ready_q <= 1'b1;
            txd        <= 1'b1;
        end else begin
            if (tick) begin
                tick_cnt <= bit_end ? '0 : tick_cnt + 1'b1;
            end
            case (state)
                spart_pkg::tx_idle: begin
                    tick_cnt <= '0;
                    // Byte pending, start bit begins on the next tick
                    if (!tx_ready_q && tick) begin
                        txd   <= 1'b0;
                        state <= spart_pkg::tx_start;
                    end else if (core.tx_start) begin
                        tx_ready_q <= 1'b0;
                    end
                end
                spart_pkg::tx_start: begin
                    if (bit_end) begin
                        txd     <= shift_q[0];
                        bit_cnt <= '0;
                        state   <= spart_pkg::tx_data;
                    end
                end
                spart_pkg::tx_data: begin
                    if (bit_end) begin
                        if (bit_cnt == spart_pkg::last_bit) begin
                            txd   <= 1'b1;
                            state <= spart_pkg::tx_stop;
                        end else begin
                            txd     <= shift_q[0];
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                spart_pkg::tx_stop: begin
                    if (bit_end) begin
                        tx_ready_q <= 1'b1;
                        state      <= spart_pkg::tx_idle;
                    end
                end
                default: state <= spart_pkg::tx_idle;
            endcase
        end
    end

    // Line must rest at mark whenever nothing is being sent
    a_idle_mark: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == spart_pkg::tx_idle) |-> txd
    );

endmodule

// File: rtl/uart_rx.sv
////////////////////////////////////////////////////////////
// 8N1 receiver with 16x oversampling
// Synchronizes rxd, validates the start bit at its middle,
// samples each data bit mid-cell and checks the stop bit
// Presents the byte with a one-clock rx_valid strobe
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module uart_rx (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     tick,
    input  logic     rxd,
    spart_core_if.rx core
);

    spart_pkg::rx_state_e                   state;
    logic [spart_pkg::data_bits-1:0]        shift_q;
    logic [spart_pkg::tick_cnt_width-1:0]   tick_cnt;
    logic [spart_pkg::bit_cnt_width-1:0]    bit_cnt;
    logic                                   rxd_meta;
    logic                                   rxd_sync;
    logic                                   rxd_prev;
    logic                                   start_edge;
    logic                                   bit_end;
    logic                                   rx_valid_q;
    logic                                   frame_err_q;

    assign core.rx_byte      = shift_q;
    assign core.rx_valid     = rx_valid_q;
    assign core.rx_frame_err = frame_err_q;

    assign start_edge = rxd_prev && !rxd_sync;
    assign bit_end    = tick && (tick_cnt == spart_pkg::last_tick);

    // Two-flop synchronizer plus one stage for edge detect
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    // Data bits arrive LSB first, so shift in from the top
    always_ff @(posedge clk) begin
        if (state == spart_pkg::rx_data && bit_end) begin
            shift_q <= {rxd_sync, shift_q[spart_pkg::data_bits-1:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= spart_pkg::rx_idle;
            tick_cnt    <= '0;
            bit_cnt     <= '0;
            rx_valid_q  <= 1'b0;
            frame_err_q <= 1'b0;
        end else begin
            rx_valid_q <= 1'b0;
            case (state)
                spart_pkg::rx_idle: begin
                    tick_cnt <= '0;
                    if (start_edge) begin
                        state <= spart_pkg::rx_start;
                    end
                end
                spart_pkg::rx_start: begin
                    if (tick) begin
                        if (tick_cnt == spart_pkg::half_tick) begin
                            // Middle of the start bit, high means a glitch
                            tick_cnt <= '0;
                            bit_cnt  <= '0;
                            state    <= rxd_sync ? spart_pkg::rx_idle : spart_pkg::rx_data;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                spart_pkg::rx_data: begin
                    if (tick) begin
                        tick_cnt <= bit_end ? '0 : tick_cnt + 1'b1;
                    end
                    if (bit_end) begin
                        if (bit_cnt == spart_pkg::last_bit) begin
                            state <= spart_pkg::rx_stop;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                spart_pkg::rx_stop: begin
                    if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                    if (bit_end) begin
                        rx_valid_q  <= 1'b1;
                        frame_err_q <= !rxd_sync;
                        state       <= spart_pkg::rx_idle;
                    end
                end
                default: state <= spart_pkg::rx_idle;
            endcase
        end
    end

    // One strobe per received character
    a_valid_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        core.rx_valid |=> !core.rx_valid
    );

endmodule

// File: rtl/spart_regs.sv
////////////////////////////////////////////////////////////
// Host register block
// Decodes the byte-wide bus into data, status and divisor
// registers, holds the received byte and the error flags,
// and turns data writes into transmit requests
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module spart_regs (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            cs,
    input  logic                            rw,
    input  logic [1:0]                      addr,
    input  logic [spart_pkg::data_bits-1:0] wdata,
    output logic [spart_pkg::data_bits-1:0] rdata,
    output logic [spart_pkg::div_width-1:0] div,
    spart_core_if.regs                      core
);

    spart_pkg::reg_addr_e              reg_sel;
    logic                              wr;
    logic                              rd;
    logic                              rd_data;
    logic                              rd_status;
    logic [spart_pkg::div_width-1:0]   div_q;
    logic [spart_pkg::data_bits-1:0]   rx_hold;
    logic [spart_pkg::data_bits-1:0]   status;
    logic                              rx_full;
    logic                              frame_err;
    logic                              overrun;

    ////////////////////////////////////////////////////////////
    // Access decode
    ////////////////////////////////////////////////////////////

    assign reg_sel   = spart_pkg::reg_addr_e'(addr);
    assign wr        = cs && !rw;
    assign rd        = cs && rw;
    assign rd_data   = rd && (reg_sel == spart_pkg::reg_data);
    assign rd_status = rd && (reg_sel == spart_pkg::reg_status);

    // Writes while the transmitter is busy are dropped here
    assign core.tx_start = wr && (reg_sel == spart_pkg::reg_data) && core.tx_ready;
    assign core.tx_data  = wdata;
    assign div           = div_q;

    always_comb begin
        status                            = '0;
        status[spart_pkg::stat_tx_ready]  = core.tx_ready;
        status[spart_pkg::stat_rx_full]   = rx_full;
        status[spart_pkg::stat_frame_err] = frame_err;
        status[spart_pkg::stat_overrun]   = overrun;
    end

    ////////////////////////////////////////////////////////////
    // Registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_q <= spart_pkg::default_div;
        end else if (wr && reg_sel == spart_pkg::reg_div_lo) begin
            div_q[7:0] <= wdata;
        end else if (wr && reg_sel == spart_pkg::reg_div_hi) begin
            div_q[15:8] <= wdata;
        end
    end

    // Receive holding register and flags
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_full   <= 1'b0;
            frame_err <= 1'b0;
            overrun   <= 1'b0;
        end else begin
            if (rd_data) begin
                rx_full   <= 1'b0;
                frame_err <= 1'b0;
            end
            if (rd_status) begin
                overrun <= 1'b0;
            end
            // New byte wins over a same-cycle clear
            if (core.rx_valid) begin
                if (rx_full && !rd_data) begin
                    overrun <= 1'b1;
                end else begin
                    rx_hold   <= core.rx_byte;
                    rx_full   <= 1'b1;
                    frame_err <= core.rx_frame_err;
                end
            end
        end
    end

    // Read data stays until the next read
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdata <= '0;
        end else if (rd) begin
            case (reg_sel)
                spart_pkg::reg_data:   rdata <= rx_hold;
                spart_pkg::reg_status: rdata <= status;
                spart_pkg::reg_div_lo: rdata <= div_q[7:0];
                spart_pkg::reg_div_hi: rdata <= div_q[15:8];
                default:               rdata <= '0;
            endcase
        end
    end

    // The transmitter takes a request on the next clock
    a_tx_handoff: assert property (
        @(posedge clk) disable iff (!rst_n)
        core.tx_start |=> !core.tx_ready
    );

endmodule

// File: rtl/spart_top.sv
////////////////////////////////////////////////////////////
// Serial port top level
// Host register bus on one side, rxd and txd on the other
// Connects the register block, baud divider and both engines
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module spart_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            cs,
    input  logic                            rw,
    input  logic [1:0]                      addr,
    input  logic [spart_pkg::data_bits-1:0] wdata,
    output logic [spart_pkg::data_bits-1:0] rdata,
    input  logic                            rxd,
    output logic                            txd
);

    logic [spart_pkg::div_width-1:0] div;
    logic                            tick;

    spart_core_if core_if ();

    spart_regs u_regs (
        .clk   (clk),
        .rst_n (rst_n),
        .cs    (cs),
        .rw    (rw),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .div   (div),
        .core  (core_if.regs)
    );

    baud_gen u_baud (
        .clk   (clk),
        .rst_n (rst_n),
        .div   (div),
        .tick  (tick)
    );

    uart_tx u_tx (
        .clk   (clk),
        .rst_n (rst_n),
        .tick  (tick),
        .core  (core_if.tx),
        .txd   (txd)
    );

    uart_rx u_rx (
        .clk   (clk),
        .rst_n (rst_n),
        .tick  (tick),
        .rxd   (rxd),
        .core  (core_if.rx)
    );

endmodule

// File: bench/spart_tb.sv
////////////////////////////////////////////////////////////
// Testbench for the serial port top level
// Drives the host bus and rxd on falling edges, models the
// line and the status flags, and checks reset state,
// transmit, receive, framing error, overrun and a new rate
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module spart_tb;

    localparam int clk_period     = 8;
    localparam int max_div        = int'(spart_pkg::default_div);
    localparam int n_tx_frames    = 4;
    localparam int n_rx_frames    = 4;
    localparam int n_short_frames = 2;
    // Framing test sends one frame, overrun test two
    localparam int total_frames   = n_tx_frames + n_rx_frames + 3 + 2 * n_short_frames;

    logic       clk;
    logic       rst_n;
    logic       cs;
    logic       rw;
    logic [1:0] addr;
    logic [7:0] wdata;
    logic [7:0] rdata;
    logic       rxd;
    logic       txd;

    // Random source and line timing
    logic [15:0] lfsr;
    int          bit_clks;
    longint      wd_ns;

    // Status model
    logic       m_full;
    logic       m_ferr;
    logic       m_ovr;
    logic [7:0] m_hold;

    spart_top i_dut (
        .clk   (clk),
        .rst_n (rst_n),
        .cs    (cs),
        .rw    (rw),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .rxd   (rxd),
        .txd   (txd)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Budget of 11 bit periods per frame at the slowest rate
    initial begin
        wd_ns = longint'(total_frames + 4) * 11 * 16 * (max_div + 1) * clk_period + 20000;
        #(wd_ns);
        report_failure("Timeout: the run did not finish in the expected time");
    end

    ////////////////////////////////////////////////////////////
    // Checking and random helpers
    ////////////////////////////////////////////////////////////

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // Galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic random_bits(input int n, output logic [7:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[6:0], lfsr[0]};
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Host bus
    ////////////////////////////////////////////////////////////

    task automatic bus_write(input logic [1:0] a, input logic [7:0] d);
        @(negedge clk);
        cs    = 1'b1;
        rw    = 1'b0;
        addr  = a;
        wdata = d;
        @(negedge clk);
        cs = 1'b0;
    endtask

    task automatic bus_read(input logic [1:0] a, output logic [7:0] d);
        @(negedge clk);
        cs   = 1'b1;
        rw   = 1'b1;
        addr = a;
        @(negedge clk);
        cs = 1'b0;
        d  = rdata;
    endtask

    ////////////////////////////////////////////////////////////
    // Status model
    ////////////////////////////////////////////////////////////

    function automatic logic [7:0] model_status(input logic txr);
        logic [7:0] s;
        s                             = '0;
        s[spart_pkg::stat_tx_ready]  = txr;
        s[spart_pkg::stat_rx_full]   = m_full;
        s[spart_pkg::stat_frame_err] = m_ferr;
        s[spart_pkg::stat_overrun]   = m_ovr;
        return s;
    endfunction

    task automatic frame_arrived(input logic [7:0] b, input logic stop_bit);
        if (m_full) begin
            m_ovr = 1'b1;
        end else begin
            m_hold = b;
            m_full = 1'b1;
            m_ferr = !stop_bit;
        end
    endtask

    task automatic check_status(input logic txr);
        logic [7:0] v;
        bus_read(spart_pkg::reg_status, v);
        check_value("status", v, model_status(txr));
        m_ovr = 1'b0;
    endtask

    task automatic read_data_check();
        logic [7:0] v;
        bus_read(spart_pkg::reg_data, v);
        check_value("rdata", v, m_hold);
        m_full = 1'b0;
        m_ferr = 1'b0;
    endtask

    task automatic poll_rx_full();
        logic [7:0] v;
        int         polls;
        logic       done;
        polls = 0;
        done  = 1'b0;
        while (!done) begin
            if (polls > bit_clks) begin
                report_failure("Receive full flag never set after a frame was sent");
            end
            bus_read(spart_pkg::reg_status, v);
            polls++;
            if (v[spart_pkg::stat_rx_full]) begin
                done = 1'b1;
            end else begin
                m_ovr = 1'b0;
            end
        end
        check_value("status", v, model_status(1'b1));
        m_ovr = 1'b0;
    endtask

    task automatic wait_tx_ready();
        logic [7:0] v;
        int         polls;
        polls = 0;
        v     = '0;
        while (v[spart_pkg::stat_tx_ready] !== 1'b1) begin
            if (polls > bit_clks) begin
                report_failure("Transmitter never returned to ready after a frame");
            end
            bus_read(spart_pkg::reg_status, v);
            m_ovr = 1'b0;
            polls++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Line model, 16 x (div+1) clocks per bit
    ////////////////////////////////////////////////////////////

    task automatic send_frame(input logic [7:0] b, input logic stop_bit);
        int i;
        @(negedge clk);
        rxd = 1'b0;
        repeat (bit_clks) @(negedge clk);
        for (i = 0; i < spart_pkg::data_bits; i++) begin
            rxd = b[i];
            repeat (bit_clks) @(negedge clk);
        end
        rxd = stop_bit;
        repeat (bit_clks) @(negedge clk);
        // One idle bit before anything else
        rxd = 1'b1;
        repeat (bit_clks) @(negedge clk);
    endtask

    task automatic capture_frame(output logic [7:0] b);
        int i;
        b = '0;
        while (txd !== 1'b0) @(negedge clk);
        repeat (bit_clks / 2) @(negedge clk);
        check_value("txd start bit", 8'(txd), 8'h00);
        for (i = 0; i < spart_pkg::data_bits; i++) begin
            repeat (bit_clks) @(negedge clk);
            b[i] = txd;
        end
        repeat (bit_clks) @(negedge clk);
        check_value("txd stop bit", 8'(txd), 8'h01);
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////

    task automatic run_tx_test(input int n);
        logic [7:0] b;
        logic [7:0] junk;
        logic [7:0] got;
        logic [7:0] v;
        int         i;
        for (i = 0; i < n; i++) begin
            random_bits(8, b);
            bus_write(spart_pkg::reg_data, b);
            if (i == 0) begin
                random_bits(8, junk);
                fork
                    capture_frame(got);
                    begin
                        bus_read(spart_pkg::reg_status, v);
                        check_value("status tx_ready", 8'(v[spart_pkg::stat_tx_ready]), 8'h00);
                        m_ovr = 1'b0;
                        bus_write(spart_pkg::reg_data, junk);
                    end
                join
            end else begin
                capture_frame(got);
            end
            check_value("txd data", got, b);
            wait_tx_ready();
            if (i == 0) begin
                // Busy write must not start a second frame
                repeat (2 * bit_clks) begin
                    @(negedge clk);
                    check_value("txd idle", 8'(txd), 8'h01);
                end
            end
        end
    endtask

    task automatic run_rx_test(input int n);
        logic [7:0] b;
        int         i;
        for (i = 0; i < n; i++) begin
            random_bits(8, b);
            send_frame(b, 1'b1);
            frame_arrived(b, 1'b1);
            poll_rx_full();
            read_data_check();
            check_status(1'b1);
        end
    endtask

    initial begin
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] r;
        logic [7:0] v;
        int         new_div;

        rst_n    = 1'b0;
        cs       = 1'b0;
        rw       = 1'b0;
        addr     = 2'd0;
        wdata    = 8'h00;
        rxd      = 1'b1;
        lfsr     = 16'd68;
        bit_clks = 16 * (max_div + 1);
        m_full   = 1'b0;
        m_ferr   = 1'b0;
        m_ovr    = 1'b0;
        m_hold   = 8'h00;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        // Reset state
        check_status(1'b1);
        check_value("txd", 8'(txd), 8'h01);

        run_tx_test(n_tx_frames);
        run_rx_test(n_rx_frames);

        // Framing error
        random_bits(8, b);
        send_frame(b, 1'b0);
        frame_arrived(b, 1'b0);
        poll_rx_full();
        read_data_check();
        check_status(1'b1);

        // Overrun keeps the first byte
        random_bits(8, a);
        random_bits(8, b);
        send_frame(a, 1'b1);
        frame_arrived(a, 1'b1);
        send_frame(b, 1'b1);
        frame_arrived(b, 1'b1);
        check_status(1'b1);
        check_status(1'b1);
        read_data_check();
        check_status(1'b1);

        // Faster rate, divisor 3 to 10
        random_bits(3, r);
        new_div = 3 + int'(r);
        bus_write(spart_pkg::reg_div_lo, 8'(new_div));
        bus_write(spart_pkg::reg_div_hi, 8'h00);
        bus_read(spart_pkg::reg_div_lo, v);
        check_value("div_lo", v, 8'(new_div));
        bit_clks = 16 * (new_div + 1);
        repeat (2 * (max_div + 1)) @(negedge clk);
        run_tx_test(n_short_frames);
        run_rx_test(n_short_frames);

        $display("test passed");
        $finish;
    end

endmodule

// File: all.f
rtl/spart_pkg.sv
rtl/spart_core_if.sv
rtl/baud_gen.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/spart_regs.sv
rtl/spart_top.sv
bench/spart_tb.sv

// File: Makefile
# Verilator flow for the serial port testbench

TOP = spart_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f all.f

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f all.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
